// File: include/decode_defs.svh
`ifndef decode_defs_svh
`define decode_defs_svh

// lsb positions of the MIPS instruction fields
localparam int op_lsb   = 26;  // op, 6 bits
localparam int rs_lsb   = 21;  // rs, 5 bits
localparam int rt_lsb   = 16;  // rt, 5 bits
localparam int rd_lsb   = 11;  // rd, 5 bits
localparam int sa_lsb   = 6;   // shift amount, 5 bits
localparam int func_lsb = 0;   // function, 6 bits
localparam int imm_lsb  = 0;   // immediate, 16 bits

`endif

// File: hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  exc_code_t;

    localparam exc_code_t exc_int = 5'd0;
    localparam exc_code_t exc_sys = 5'd8;
    localparam exc_code_t exc_bp  = 5'd9;
    localparam exc_code_t exc_ri  = 5'd10;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_j, br_jal, br_jr
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        br_kind_t  br_kind;
        reg_addr_t dest;         // 0 when nothing is written
        logic      uses_rs;
        logic      uses_rt;
        logic      load_op;
        logic      mem_we;
        logic      gr_we;
        logic      src1_is_sa;
        logic      src2_is_imm;
        logic      src2_is_8;
        logic      is_syscall;
        logic      is_break;
        logic      defined;
        word_t     imm_value;    // already extended
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      fs_ex;
        exc_code_t fs_exc_code;
    } fs_to_ds_t;

    typedef struct packed {
        reg_addr_t dest;
        word_t     result;
        logic      is_load;
    } fwd_src_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_to_rf_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     rt_value;     // store data
        logic      load_op;
        logic      mem_we;
        logic      gr_we;
        reg_addr_t dest;
        br_kind_t  br_kind;
        word_t     br_target;
        logic      ex;
        exc_code_t exc_code;
    } ds_to_es_t;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  decode_pkg::word_t inst,
    output decode_pkg::ctrl_t ctrl
);
    import decode_pkg::*;
    `include "decode_defs.svh"

    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [5:0]  func;
    logic [15:0] imm;
    logic        special;
    logic        inst_addu, inst_subu, inst_slt, inst_sltu;
    logic        inst_and, inst_or, inst_xor, inst_nor;
    logic        inst_sll, inst_srl, inst_sra;
    logic        inst_addiu, inst_lui, inst_andi, inst_ori, inst_xori;
    logic        inst_slti, inst_sltiu, inst_lw, inst_sw;
    logic        inst_beq, inst_bne, inst_j, inst_jal, inst_jr;
    logic        inst_syscall, inst_break;
    logic        imm_zero_ext;
    logic        imm_form;
    logic        no_dest;

    assign op   = inst[op_lsb +: 6];
    assign rs   = inst[rs_lsb +: 5];
    assign rt   = inst[rt_lsb +: 5];
    assign rd   = inst[rd_lsb +: 5];
    assign sa   = inst[sa_lsb +: 5];
    assign func = inst[func_lsb +: 6];
    assign imm  = inst[imm_lsb +: 16];

    assign special = (op == 6'h00);

    // three-register forms need sa == 0
    assign inst_addu    = special & (func == 6'h21) & (sa == 5'd0);
    assign inst_subu    = special & (func == 6'h23) & (sa == 5'd0);
    assign inst_slt     = special & (func == 6'h2a) & (sa == 5'd0);
    assign inst_sltu    = special & (func == 6'h2b) & (sa == 5'd0);
    assign inst_and     = special & (func == 6'h24) & (sa == 5'd0);
    assign inst_or      = special & (func == 6'h25) & (sa == 5'd0);
    assign inst_xor     = special & (func == 6'h26) & (sa == 5'd0);
    assign inst_nor     = special & (func == 6'h27) & (sa == 5'd0);
    assign inst_sll     = special & (func == 6'h00) & (rs == 5'd0);  // also nop
    assign inst_srl     = special & (func == 6'h02) & (rs == 5'd0);
    assign inst_sra     = special & (func == 6'h03) & (rs == 5'd0);
    assign inst_jr      = special & (func == 6'h08) & (rt == 5'd0) & (rd == 5'd0) & (sa == 5'd0);
    assign inst_syscall = special & (func == 6'h0c);
    assign inst_break   = special & (func == 6'h0d);
    assign inst_j       = (op == 6'h02);
    assign inst_jal     = (op == 6'h03);
    assign inst_beq     = (op == 6'h04);
    assign inst_bne     = (op == 6'h05);
    assign inst_addiu   = (op == 6'h09);
    assign inst_slti    = (op == 6'h0a);
    assign inst_sltiu   = (op == 6'h0b);
    assign inst_andi    = (op == 6'h0c);
    assign inst_ori     = (op == 6'h0d);
    assign inst_xori    = (op == 6'h0e);
    assign inst_lui     = (op == 6'h0f) & (rs == 5'd0);
    assign inst_lw      = (op == 6'h23);
    assign inst_sw      = (op == 6'h2b);

    assign imm_zero_ext = inst_andi | inst_ori | inst_xori | inst_lui;
    assign imm_form     = imm_zero_ext | inst_addiu | inst_slti | inst_sltiu;
    assign no_dest      = inst_sw | inst_beq | inst_bne | inst_j | inst_jr
                        | inst_syscall | inst_break;

    always_comb begin
        ctrl = '0;
        if (inst_subu)                   ctrl.alu_op = alu_sub;
        else if (inst_slt | inst_slti)   ctrl.alu_op = alu_slt;
        else if (inst_sltu | inst_sltiu) ctrl.alu_op = alu_sltu;
        else if (inst_and | inst_andi)   ctrl.alu_op = alu_and;
        else if (inst_nor)               ctrl.alu_op = alu_nor;
        else if (inst_or | inst_ori)     ctrl.alu_op = alu_or;
        else if (inst_xor | inst_xori)   ctrl.alu_op = alu_xor;
        else if (inst_sll)               ctrl.alu_op = alu_sll;
        else if (inst_srl)               ctrl.alu_op = alu_srl;
        else if (inst_sra)               ctrl.alu_op = alu_sra;
        else if (inst_lui)               ctrl.alu_op = alu_lui;
        else                             ctrl.alu_op = alu_add;  // addu, addiu, lw, sw, jal

        if (inst_beq)      ctrl.br_kind = br_beq;
        else if (inst_bne) ctrl.br_kind = br_bne;
        else if (inst_j)   ctrl.br_kind = br_j;
        else if (inst_jal) ctrl.br_kind = br_jal;
        else if (inst_jr)  ctrl.br_kind = br_jr;
        else               ctrl.br_kind = br_none;

        if (inst_jal)                  ctrl.dest = 5'd31;
        else if (imm_form | inst_lw)   ctrl.dest = rt;
        else if (no_dest)              ctrl.dest = 5'd0;
        else                           ctrl.dest = rd;

        // rs bits belong to the index or the code field here
        ctrl.uses_rs     = ~(inst_j | inst_jal | inst_syscall | inst_break);
        ctrl.uses_rt     = ~(imm_form | inst_lw | inst_jal);
        ctrl.load_op     = inst_lw;
        ctrl.mem_we      = inst_sw;
        ctrl.gr_we       = ~no_dest;
        ctrl.src1_is_sa  = inst_sll | inst_srl | inst_sra;
        ctrl.src2_is_imm = imm_form | inst_lw | inst_sw;
        ctrl.src2_is_8   = inst_jal;  // link address is pc + 8
        ctrl.is_syscall  = inst_syscall;
        ctrl.is_break    = inst_break;
        ctrl.defined     = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                         | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_addiu
                         | inst_lui | inst_andi | inst_ori | inst_xori | inst_slti
                         | inst_sltiu | inst_lw | inst_sw | inst_beq | inst_bne | inst_j
                         | inst_jal | inst_jr | inst_syscall | inst_break;
        ctrl.imm_value   = imm_zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2,
    input  decode_pkg::wb_to_rf_t wr
);
    import decode_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != 5'd0) begin  // $0 stays zero
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no write-through, writeback value comes via wb_fwd
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic                  valid,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  decode_pkg::word_t     rf_rs,
    input  decode_pkg::word_t     rf_rt,
    input  decode_pkg::fwd_src_t  exe_fwd,
    input  decode_pkg::fwd_src_t  mem_fwd,
    input  decode_pkg::fwd_src_t  wb_fwd,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  load_stall
);
    import decode_pkg::*;

    logic rs_wait;
    logic rt_wait;

    function automatic logic hits(input reg_addr_t addr);
        return (addr == exe_fwd.dest) || (addr == mem_fwd.dest) || (addr == wb_fwd.dest);
    endfunction

    // exe wins over mem, mem over wb
    function automatic word_t bypass(input reg_addr_t addr);
        if (addr == exe_fwd.dest) begin
            return exe_fwd.result;
        end else if (addr == mem_fwd.dest) begin
            return mem_fwd.result;
        end
        return wb_fwd.result;
    endfunction

    assign rs_wait = valid && uses_rs && (rs != 5'd0) && hits(rs);
    assign rt_wait = valid && uses_rt && (rt != 5'd0) && hits(rt);

    assign rs_value = rs_wait ? bypass(rs) : rf_rs;
    assign rt_value = rt_wait ? bypass(rt) : rf_rt;

    // load data only exists after mem, so an exe match must wait
    assign load_stall = exe_fwd.is_load
                        && ((rs_wait && rs == exe_fwd.dest) || (rt_wait && rt == exe_fwd.dest));

endmodule

`default_nettype wire

// File: hdl/int_marker.sv
`timescale 1ns/1ps
`default_nettype none

module int_marker (
    input  logic clk,
    input  logic reset,
    input  logic has_int,
    input  logic ds_valid,
    input  logic handoff,
    output logic int_mark
);
    typedef enum logic [1:0] {
        idle,
        armed,     // one instruction carries the interrupt
        drained    // waits for the request to drop after the handoff
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        int_mark   = 1'b0;
        case (state)
            idle: begin
                if (has_int && ds_valid) begin
                    int_mark   = 1'b1;
                    next_state = handoff ? drained : armed;  // may leave in the same cycle
                end
            end
            armed: begin
                int_mark = 1'b1;  // held until the instruction leaves
                if (handoff) next_state = drained;
            end
            drained: begin
                if (!has_int) next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::ds_to_es_t ds_to_es,
    input  logic                  es_allowin,
    output logic                  is_branch,
    input  decode_pkg::wb_to_rf_t wb_to_rf,
    input  decode_pkg::fwd_src_t  exe_fwd,
    input  decode_pkg::fwd_src_t  mem_fwd,
    input  decode_pkg::fwd_src_t  wb_fwd,
    input  logic                  int_pending,
    input  logic                  status_ie,
    input  logic                  status_exl
);
    import decode_pkg::*;

    logic      ds_valid;
    fs_to_ds_t fs_to_ds_r;
    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_value;
    word_t     rt_value;
    word_t     pc_plus4;
    logic      load_stall;
    logic      ds_ready_go;
    logic      has_int;
    logic      int_mark;

    assign ds_ready_go    = ~load_stall;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid   <= 1'b0;
            fs_to_ds_r <= '0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
            if (fs_to_ds_valid) fs_to_ds_r <= fs_to_ds;
        end
    end

    assign rs       = fs_to_ds_r.inst[25:21];
    assign rt       = fs_to_ds_r.inst[20:16];
    assign pc_plus4 = fs_to_ds_r.pc + 32'd4;
    assign has_int  = int_pending & status_ie & ~status_exl;

    inst_decoder u_dec (.inst(fs_to_ds_r.inst), .ctrl(ctrl));

    regfile u_rf (
        .clk(clk), .reset(reset),
        .raddr1(rs), .raddr2(rt),
        .rdata1(rf_rs), .rdata2(rf_rt),
        .wr(wb_to_rf)
    );

    operand_forward u_fwd (
        .valid(ds_valid), .uses_rs(ctrl.uses_rs), .uses_rt(ctrl.uses_rt),
        .rs(rs), .rt(rt), .rf_rs(rf_rs), .rf_rt(rf_rt),
        .exe_fwd(exe_fwd), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
        .rs_value(rs_value), .rt_value(rt_value), .load_stall(load_stall)
    );

    int_marker u_int (
        .clk(clk), .reset(reset), .has_int(has_int), .ds_valid(ds_valid),
        .handoff(ds_to_es_valid & es_allowin), .int_mark(int_mark)
    );

    assign is_branch = ds_valid & (ctrl.br_kind != br_none);

    always_comb begin
        ds_to_es          = '0;
        ds_to_es.pc       = fs_to_ds_r.pc;
        ds_to_es.alu_op   = ctrl.alu_op;
        ds_to_es.rt_value = rt_value;
        ds_to_es.load_op  = ctrl.load_op;
        ds_to_es.mem_we   = ctrl.mem_we;
        ds_to_es.gr_we    = ctrl.gr_we;
        ds_to_es.dest     = ctrl.dest;
        ds_to_es.br_kind  = ctrl.br_kind;

        if (ctrl.src1_is_sa)            ds_to_es.src1 = {27'd0, ctrl.imm_value[10:6]};
        else if (ctrl.br_kind == br_jal) ds_to_es.src1 = fs_to_ds_r.pc;
        else                            ds_to_es.src1 = rs_value;

        if (ctrl.src2_is_imm)     ds_to_es.src2 = ctrl.imm_value;
        else if (ctrl.src2_is_8)  ds_to_es.src2 = 32'd8;
        else                      ds_to_es.src2 = rt_value;

        case (ctrl.br_kind)
            br_beq, br_bne: ds_to_es.br_target = pc_plus4 + {ctrl.imm_value[29:0], 2'b00};
            br_j, br_jal:   ds_to_es.br_target = {pc_plus4[31:28], fs_to_ds_r.inst[25:0], 2'b00};
            br_jr:          ds_to_es.br_target = rs_value;
            default:        ds_to_es.br_target = '0;
        endcase

        // fetch exception first, then interrupt, ri, syscall, break
        ds_to_es.ex = fs_to_ds_r.fs_ex | int_mark | ~ctrl.defined
                    | ctrl.is_syscall | ctrl.is_break;
        if (fs_to_ds_r.fs_ex)    ds_to_es.exc_code = fs_to_ds_r.fs_exc_code;
        else if (int_mark)       ds_to_es.exc_code = exc_int;
        else if (!ctrl.defined)  ds_to_es.exc_code = exc_ri;
        else if (ctrl.is_syscall) ds_to_es.exc_code = exc_sys;
        else if (ctrl.is_break)  ds_to_es.exc_code = exc_bp;
    end

endmodule

`default_nettype wire

// File: dv/decode_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input logic                  ds_to_es_valid,
    input logic                  ds_allowin,
    input logic                  es_allowin,
    input decode_pkg::ds_to_es_t ds_to_es,
    input logic                  load_stall,
    input logic                  int_mark,
    input logic                  has_int
);
    logic handoff;

    assign handoff = ds_to_es_valid & es_allowin;

    // stage comes out of reset empty and open
    reset_empty: assert property (@(posedge clk) reset |=> (!ds_to_es_valid && ds_allowin))
        else $error("stage not empty after reset");

    hold_stable: assert property (@(posedge clk) disable iff (reset || flush)
        (ds_to_es_valid && !es_allowin) |=> $stable(ds_to_es))
        else $error("ds_to_es changed under back-pressure");

    // a stalled instruction stays in the stage
    stall_blocks: assert property (@(posedge clk) disable iff (reset || flush)
        load_stall |=> ((load_stall || ds_to_es_valid) && $stable(ds_to_es.pc)))
        else $error("stalled instruction left or changed");

    // at most one marked handoff until the request drops
    one_mark: assert property (@(posedge clk) disable iff (reset)
        (handoff && int_mark) |=> !(handoff && int_mark) until !has_int)
        else $error("second interrupt mark in one episode");

endmodule

bind decode_stage decode_stage_checker chk0 (
    .clk(clk), .reset(reset), .flush(flush),
    .ds_to_es_valid(ds_to_es_valid), .ds_allowin(ds_allowin),
    .es_allowin(es_allowin), .ds_to_es(ds_to_es),
    .load_stall(load_stall), .int_mark(int_mark), .has_int(has_int)
);

`default_nettype wire

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
    import decode_pkg::*;

    localparam int n_inst = 200;
    localparam int limit  = 4 * n_inst + 100;
    // {op, func} per instruction kind
    // kind 27 has an undefined opcode
    localparam logic [11:0] code_tab [28] = '{
        12'h021, 12'h023, 12'h02a, 12'h02b, 12'h024, 12'h025, 12'h026, 12'h027,
        12'h000, 12'h002, 12'h003, 12'h240, 12'h280, 12'h2c0, 12'h300, 12'h340,
        12'h380, 12'h3c0, 12'h8c0, 12'hac0, 12'h100, 12'h140, 12'h080, 12'h0c0,
        12'h008, 12'h00c, 12'h00d, 12'hfc0};

    logic      clk = 1'b0;
    logic      reset, flush, fs_to_ds_valid, es_allowin;
    logic      int_pending, status_ie, status_exl;
    logic      ds_allowin, ds_to_es_valid, is_branch;
    fs_to_ds_t fs_to_ds;
    ds_to_es_t ds_to_es, exp;
    wb_to_rf_t wb_to_rf;
    fwd_src_t  exe_fwd, mem_fwd, wb_fwd;
    word_t     shadow [32];
    word_t     seed = 32'h93c6_2d38;
    word_t     cur_inst, cur_pc;
    int        cur_kind, cycles = 0;
    logic      cur_fs_ex, cur_mark, fresh, in_flight, stall_exp;
    exc_code_t cur_code;
    logic      handoff;

    always #5 clk = ~clk;

    decode_stage dut0 (.*);

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t encode(input int kind, input word_t r);
        logic [5:0] op;
        logic [5:0] fn;
        op = code_tab[kind][11:6];
        fn = code_tab[kind][5:0];
        if (kind < 8) return {6'd0, r[25:11], 5'd0, fn};
        if (kind < 11) return {11'd0, r[20:6], fn};
        if (kind == 17) return {op, 5'd0, r[20:0]};
        if (kind == 24) return {6'd0, r[25:21], 15'd0, fn};
        if (kind == 25 || kind == 26) return {6'd0, r[25:6], fn};
        return {op, r[25:0]};
    endfunction

    // bypass priority exe, mem, wb, then register file
    function automatic word_t operand(input reg_addr_t a, input logic uses);
        if (uses && a != 5'd0 && a == exe_fwd.dest) return exe_fwd.result;
        if (uses && a != 5'd0 && a == mem_fwd.dest) return mem_fwd.result;
        if (uses && a != 5'd0 && a == wb_fwd.dest) return wb_fwd.result;
        return (a == 5'd0) ? '0 : shadow[a];
    endfunction

    function automatic ds_to_es_t expect_out();
        ds_to_es_t e;
        int        k;
        logic      imm_form, no_dest, uses_rs, uses_rt;
        word_t     imm, rsv, pc4;
        k        = cur_kind;
        imm_form = (k >= 11 && k <= 17);
        no_dest  = (k == 19 || k == 20 || k == 21 || k == 22 || k >= 24) && k != 27;
        uses_rs  = !(k == 22 || k == 23 || k == 25 || k == 26);
        uses_rt  = !(imm_form || k == 18 || k == 23);
        if (k >= 14 && k <= 17) imm = {16'd0, cur_inst[15:0]};
        else imm = {{16{cur_inst[15]}}, cur_inst[15:0]};
        rsv = operand(cur_inst[25:21], uses_rs);
        pc4 = cur_pc + 32'd4;
        e          = '0;
        e.pc       = cur_pc;
        e.rt_value = operand(cur_inst[20:16], uses_rt);
        e.load_op  = (k == 18);
        e.mem_we   = (k == 19);
        e.gr_we    = !no_dest;
        case (k)
            1: e.alu_op = alu_sub;
            2, 12: e.alu_op = alu_slt;
            3, 13: e.alu_op = alu_sltu;
            4, 14: e.alu_op = alu_and;
            5, 15: e.alu_op = alu_or;
            6, 16: e.alu_op = alu_xor;
            7: e.alu_op = alu_nor;
            8: e.alu_op = alu_sll;
            9: e.alu_op = alu_srl;
            10: e.alu_op = alu_sra;
            17: e.alu_op = alu_lui;
            default: e.alu_op = alu_add;
        endcase
        if (k == 23) e.dest = 5'd31;
        else if (imm_form || k == 18) e.dest = cur_inst[20:16];
        else if (no_dest) e.dest = 5'd0;
        else e.dest = cur_inst[15:11];
        if (k >= 8 && k <= 10) e.src1 = {27'd0, cur_inst[10:6]};
        else if (k == 23) e.src1 = cur_pc;
        else e.src1 = rsv;
        if (imm_form || k == 18 || k == 19) e.src2 = imm;
        else if (k == 23) e.src2 = 32'd8;
        else e.src2 = e.rt_value;
        case (k)
            20, 21: e.br_target = pc4 + {imm[29:0], 2'b00};
            22, 23: e.br_target = {pc4[31:28], cur_inst[25:0], 2'b00};
            24: e.br_target = rsv;
            default: e.br_target = '0;
        endcase
        case (k)
            20: e.br_kind = br_beq;
            21: e.br_kind = br_bne;
            22: e.br_kind = br_j;
            23: e.br_kind = br_jal;
            24: e.br_kind = br_jr;
            default: e.br_kind = br_none;
        endcase
        e.ex = cur_fs_ex | cur_mark | (k == 27) | (k == 25) | (k == 26);
        if (cur_fs_ex) e.exc_code = cur_code;
        else if (cur_mark) e.exc_code = exc_int;
        else if (k == 27) e.exc_code = exc_ri;
        else if (k == 25) e.exc_code = exc_sys;
        else if (k == 26) e.exc_code = exc_bp;
        return e;
    endfunction

    always_comb exp = expect_out();
    assign handoff = ds_to_es_valid & es_allowin;

    task automatic fail_value(input string name, input word_t got, input word_t want);
        $display("Fail %s: got %h expected %h", name, got, want);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    a_pc: assert property (@(posedge clk) disable iff (reset) handoff |-> ds_to_es.pc == exp.pc)
        else fail_value("ds_to_es.pc", $sampled(ds_to_es.pc), $sampled(exp.pc));
    a_alu: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.alu_op == exp.alu_op)
        else fail_value("ds_to_es.alu_op", $sampled(ds_to_es.alu_op), $sampled(exp.alu_op));
    a_dest: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.dest == exp.dest)
        else fail_value("ds_to_es.dest", $sampled(ds_to_es.dest), $sampled(exp.dest));
    a_flags: assert property (@(posedge clk) disable iff (reset) handoff |->
        {ds_to_es.gr_we, ds_to_es.mem_we, ds_to_es.load_op} == {exp.gr_we, exp.mem_we, exp.load_op})
        else fail_value("ds_to_es.{gr_we,mem_we,load_op}",
            $sampled({ds_to_es.gr_we, ds_to_es.mem_we, ds_to_es.load_op}),
            $sampled({exp.gr_we, exp.mem_we, exp.load_op}));
    a_src1: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.src1 == exp.src1)
        else fail_value("ds_to_es.src1", $sampled(ds_to_es.src1), $sampled(exp.src1));
    a_src2: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.src2 == exp.src2)
        else fail_value("ds_to_es.src2", $sampled(ds_to_es.src2), $sampled(exp.src2));
    a_rtv: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.rt_value == exp.rt_value)
        else fail_value("ds_to_es.rt_value", $sampled(ds_to_es.rt_value), $sampled(exp.rt_value));
    a_brk: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.br_kind == exp.br_kind)
        else fail_value("ds_to_es.br_kind", $sampled(ds_to_es.br_kind), $sampled(exp.br_kind));
    a_brt: assert property (@(posedge clk) disable iff (reset)
        handoff |-> ds_to_es.br_target == exp.br_target)
        else fail_value("ds_to_es.br_target", $sampled(ds_to_es.br_target),
            $sampled(exp.br_target));
    a_isbr: assert property (@(posedge clk) disable iff (reset)
        handoff |-> is_branch == (exp.br_kind != br_none))
        else fail_value("is_branch", $sampled(is_branch), $sampled(exp.br_kind != br_none));
    a_exc: assert property (@(posedge clk) disable iff (reset)
        handoff |-> {ds_to_es.ex, ds_to_es.exc_code} == {exp.ex, exp.exc_code})
        else fail_value("ds_to_es.{ex,exc_code}", $sampled({ds_to_es.ex, ds_to_es.exc_code}),
            $sampled({exp.ex, exp.exc_code}));
    a_flight: assert property (@(posedge clk) disable iff (reset) handoff |-> in_flight)
        else fail_plain("an instruction left the stage that was flushed or never issued");
    a_stall: assert property (@(posedge clk) disable iff (reset)
        stall_exp |-> (!ds_to_es_valid && !ds_allowin))
        else fail_plain("load-use hazard did not stall the stage");
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |-> !ds_allowin)
        else fail_plain("stage accepted input while execute held it back");

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) fail_plain("timeout waiting for the DUT to hand off");
    end

    task automatic wait_handoff();
        logic hs;
        do begin
            @(posedge clk);
            hs = handoff;  // settled value from before this edge
            #1;
        end while (!hs);
        in_flight = 1'b0;
        if (cur_mark) fresh = 1'b0;  // episode used up
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic reg_addr_t pick_dest(input word_t inst);
        word_t r;
        r = next_rand();
        case (r[1:0])
            2'd0: return inst[25:21];
            2'd1: return inst[20:16];
            2'd2: return 5'd0;
            default: return r[12:8];
        endcase
    endfunction

    initial begin
        word_t r;
        int    mode;
        reset = 1'b1;
        flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        wb_to_rf = '0;
        exe_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        int_pending = 1'b0;
        status_ie = 1'b1;
        status_exl = 1'b0;
        cur_kind = 0;
        cur_inst = '0;
        cur_pc = '0;
        cur_fs_ex = 1'b0;
        cur_code = '0;
        cur_mark = 1'b0;
        fresh = 1'b0;
        in_flight = 1'b0;
        stall_exp = 1'b0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        idle(2);
        reset = 1'b0;
        for (int i = 0; i < 32; i++) begin  // $0 write must be ignored
            wb_to_rf = '{we: 1'b1, waddr: 5'(i), wdata: next_rand()};
            if (i != 0) shadow[i] = wb_to_rf.wdata;
            idle(1);
        end
        wb_to_rf = '0;
        for (int i = 0; i < n_inst; i++) begin
            mode = i % 20;
            if (mode == 5) begin
                int_pending = 1'b1;
                fresh = 1'b1;
            end else if (mode == 15) begin
                int_pending = 1'b0;
                idle(2);
            end
            cur_kind = (mode == 2) ? 0 : int'(next_rand() % 28);
            r = next_rand();
            cur_inst = encode(cur_kind, r);
            cur_pc = next_rand() & ~32'd3;
            r = next_rand();
            cur_fs_ex = (r[3:0] == 4'd0) && mode != 2;
            cur_code = r[8:4];
            cur_mark = int_pending && fresh;
            exe_fwd = '{dest: pick_dest(cur_inst), result: next_rand(), is_load: 1'b0};
            mem_fwd = '{dest: pick_dest(cur_inst), result: next_rand(), is_load: 1'b0};
            wb_fwd = '{dest: pick_dest(cur_inst), result: next_rand(), is_load: 1'b0};
            if (mode == 2) begin
                cur_inst[21] = 1'b1;  // nonzero rs
                exe_fwd = '{dest: cur_inst[25:21], result: next_rand(), is_load: 1'b1};
            end
            if (mode == 3 || mode == 18) es_allowin = 1'b0;
            fs_to_ds = '{pc: cur_pc, inst: cur_inst, fs_ex: cur_fs_ex, fs_exc_code: cur_code};
            fs_to_ds_valid = 1'b1;
            in_flight = 1'b1;
            idle(1);
            fs_to_ds_valid = 1'b0;
            if (mode == 2) begin
                stall_exp = 1'b1;
                idle(3);
                stall_exp = 1'b0;
                exe_fwd.is_load = 1'b0;
            end else if (mode == 3) begin
                idle(3);
                es_allowin = 1'b1;
            end else if (mode == 18) begin
                flush = 1'b1;
                in_flight = 1'b0;
                idle(1);
                flush = 1'b0;
                idle(1);
                es_allowin = 1'b1;
                idle(2);
                continue;
            end
            wait_handoff();
        end
        idle(3);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_stage.f
+incdir+include
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/int_marker.sv
hdl/decode_stage.sv
dv/decode_stage_checker.sv
dv/decode_stage_tb.sv
